//--- design/sprite_video_pkg.sv
package sprite_video_pkg;

	typedef logic [9:0] coord_t;	// one screen coordinate

	// one beam sample from the timing generator
	typedef struct packed {
		coord_t hpos;
		coord_t vpos;
		logic display_on;
		logic hsync;
		logic vsync;
	} beam_t;

	// beam sample with pre-decoded sprite events
	typedef struct packed {
		beam_t beam;
		logic vstart;	// on the player's row
		logic load;		// inside hsync, row fetch allowed
		logic hstart;	// on the player's column
	} trigger_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} player_pos_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef logic [15:0] sprite_row_t;	// bit c is column c

	localparam int sprite_size = 16;

	// lsb is the leftmost column
	localparam sprite_row_t sprite_bitmap [sprite_size] = '{
		16'h001F, 16'h003F, 16'h0FFF, 16'h3FFF,
		16'h7F0F, 16'hFE07, 16'hFC03, 16'hF801,
		16'hF803, 16'hFC07, 16'hFE0F, 16'h7FFF,
		16'h3FFC, 16'h0FF0, 16'h03C0, 16'h0180
	};

endpackage

//--- design/video_timing.sv
module video_timing #(
	parameter int h_display = 640,
	parameter int h_front = 16,
	parameter int h_sync = 96,
	parameter int h_back = 48,
	parameter int v_display = 480,
	parameter int v_front = 10,
	parameter int v_sync = 2,
	parameter int v_back = 33
) (
	input logic clk,
	input logic reset,
	output sprite_video_pkg::beam_t beam
);
	import sprite_video_pkg::*;

	localparam int h_total = h_display + h_front + h_sync + h_back;
	localparam int v_total = v_display + v_front + v_sync + v_back;
	localparam int h_sync_start = h_display + h_front;
	localparam int h_sync_end = h_sync_start + h_sync;
	localparam int v_sync_start = v_display + v_front;
	localparam int v_sync_end = v_sync_start + v_sync;

	coord_t hcount;
	coord_t vcount;
	logic line_end;
	logic frame_end;

	assign line_end = hcount == coord_t'(h_total - 1);
	assign frame_end = vcount == coord_t'(v_total - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			if (frame_end)
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;	// next line
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// decode registered alongside the position so the sample stays consistent
	always_ff @(posedge clk) begin
		if (reset) begin
			beam <= '0;
		end else begin
			beam.hpos <= hcount;
			beam.vpos <= vcount;
			beam.display_on <= (hcount < coord_t'(h_display)) &&
				(vcount < coord_t'(v_display));
			beam.hsync <= (hcount >= coord_t'(h_sync_start)) &&
				(hcount < coord_t'(h_sync_end));
			beam.vsync <= (vcount >= coord_t'(v_sync_start)) &&
				(vcount < coord_t'(v_sync_end));
		end
	end

endmodule

//--- design/player_motion.sv
module player_motion #(
	parameter int h_display = 640,
	parameter int v_display = 480,
	parameter int move_period = 4
) (
	input logic clk,
	input logic reset,
	input sprite_video_pkg::joy_t buttons,
	input sprite_video_pkg::beam_t beam,
	output sprite_video_pkg::player_pos_t pos
);
	import sprite_video_pkg::*;

	localparam int cnt_w = (move_period > 1) ? $clog2(move_period) : 1;
	localparam coord_t x_max = coord_t'(h_display - sprite_size);
	localparam coord_t y_max = coord_t'(v_display - sprite_size - 1);

	logic vsync_q;
	logic frame_tick;
	logic step_now;
	logic [cnt_w-1:0] frame_cnt;

	assign frame_tick = beam.vsync & ~vsync_q;	// first vsync cycle
	assign step_now = frame_tick && (frame_cnt == cnt_w'(move_period - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_q <= 1'b0;
			frame_cnt <= '0;
		end else begin
			vsync_q <= beam.vsync;
			if (frame_tick)
				frame_cnt <= step_now ? '0 : frame_cnt + 1'b1;
		end
	end

	// direction by priority first, then refused at the edge
	always_ff @(posedge clk) begin
		if (reset) begin
			pos.x <= coord_t'(h_display / 2);
			pos.y <= coord_t'(v_display / 2);
		end else if (step_now) begin
			if (buttons.left) begin
				if (pos.x != '0)
					pos.x <= pos.x - 1'b1;
			end else if (buttons.right) begin
				if (pos.x < x_max)
					pos.x <= pos.x + 1'b1;
			end else if (buttons.up) begin
				if (pos.y != '0)
					pos.y <= pos.y - 1'b1;
			end else if (buttons.down) begin
				if (pos.y < y_max)
					pos.y <= pos.y + 1'b1;
			end
		end
	end

endmodule

//--- design/sprite_trigger.sv
module sprite_trigger (
	input logic clk,
	input logic reset,
	input sprite_video_pkg::beam_t beam,
	input sprite_video_pkg::player_pos_t pos,
	output sprite_video_pkg::trigger_t trig
);
	import sprite_video_pkg::*;

	trigger_t trig_next;

	// compare beam against player corner
	always_comb begin
		trig_next.beam = beam;
		trig_next.vstart = beam.vpos == pos.y;	// whole row y
		trig_next.load = beam.hsync;			// fetch happens in blanking
		trig_next.hstart = beam.hpos == pos.x;
	end

	// one cycle of latency, beam and flags stay together
	always_ff @(posedge clk) begin
		if (reset)
			trig <= '0;
		else
			trig <= trig_next;
	end

endmodule

//--- design/sprite_renderer.sv
module sprite_renderer (
	input logic clk,
	input logic reset,
	input sprite_video_pkg::trigger_t trig,
	input logic mirror,
	output logic gfx,
	output logic in_progress
);
	import sprite_video_pkg::*;

	typedef enum logic [2:0] {
		WAIT_FOR_VSTART,
		WAIT_FOR_LOAD,
		LOAD_ROW,
		WAIT_FOR_HSTART,
		DRAW
	} state_t;

	state_t state;
	logic [3:0] ycount;		// sprite rows drawn so far
	logic [3:0] xcount;		// column being drawn
	sprite_row_t outbits;	// current row

	// right half reads the left half backwards when mirrored
	function automatic logic pick_pixel(sprite_row_t bits, logic [3:0] col, logic mir);
		logic [3:0] idx;
		idx = (mir && col[3]) ? ~col : col;	// ~col is 15 - col
		return bits[idx];
	endfunction

	assign in_progress = state != WAIT_FOR_VSTART;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WAIT_FOR_VSTART;
			ycount <= '0;
			xcount <= '0;
			gfx <= 1'b0;
		end else begin
			case (state)
				WAIT_FOR_VSTART: begin
					ycount <= '0;
					gfx <= 1'b0;
					if (trig.vstart)
						state <= WAIT_FOR_LOAD;
				end
				WAIT_FOR_LOAD: begin
					xcount <= '0;
					gfx <= 1'b0;
					if (trig.load)
						state <= LOAD_ROW;
				end
				LOAD_ROW: begin
					state <= WAIT_FOR_HSTART;
				end
				WAIT_FOR_HSTART: begin
					if (trig.hstart) begin
						gfx <= pick_pixel(outbits, 4'd0, mirror);	// column 0 right away
						xcount <= 4'd1;
						state <= DRAW;
					end
				end
				DRAW: begin
					gfx <= pick_pixel(outbits, xcount, mirror);
					xcount <= xcount + 1'b1;
					if (xcount == 4'd15) begin
						ycount <= ycount + 1'b1;
						if (ycount == 4'd15)	// last row done
							state <= WAIT_FOR_VSTART;
						else
							state <= WAIT_FOR_LOAD;
					end
				end
				default: begin
					state <= WAIT_FOR_VSTART;
				end
			endcase
		end
	end

	// row data latched in the load window
	always_ff @(posedge clk) begin
		if (state == LOAD_ROW)
			outbits <= sprite_bitmap[ycount];
	end

endmodule

//--- design/pixel_mixer.sv
module pixel_mixer (
	input logic clk,
	input logic reset,
	input sprite_video_pkg::trigger_t trig,
	input logic gfx,
	input logic in_progress,
	output logic hsync,
	output logic vsync,
	output logic [2:0] rgb
);
	import sprite_video_pkg::*;

	beam_t beam_d;	// lines up with gfx
	logic red;
	logic green;
	logic blue;

	always_ff @(posedge clk) begin
		if (reset)
			beam_d <= '0;
		else
			beam_d <= trig.beam;
	end

	// colour only inside the visible area
	assign red = beam_d.display_on & gfx;
	assign green = beam_d.display_on & gfx;
	assign blue = beam_d.display_on & in_progress;

	// syncs and colour leave on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			rgb <= '0;
		end else begin
			hsync <= beam_d.hsync;
			vsync <= beam_d.vsync;
			rgb <= {blue, green, red};
		end
	end

endmodule

//--- design/sprite_video_top.sv
module sprite_video_top #(
	parameter int h_display = 640,
	parameter int h_front = 16,
	parameter int h_sync = 96,
	parameter int h_back = 48,
	parameter int v_display = 480,
	parameter int v_front = 10,
	parameter int v_sync = 2,
	parameter int v_back = 33,
	parameter int move_period = 4
) (
	input logic clk,
	input logic reset,
	input sprite_video_pkg::joy_t buttons,
	input logic mirror,
	output logic hsync,
	output logic vsync,
	output logic [2:0] rgb,
	output logic [3:0] led
);
	import sprite_video_pkg::*;

	beam_t beam;
	player_pos_t pos;
	trigger_t trig;
	logic gfx;
	logic in_progress;

	assign led = buttons;	// up, down, left, right

	video_timing #(
		.h_display(h_display),
		.h_front(h_front),
		.h_sync(h_sync),
		.h_back(h_back),
		.v_display(v_display),
		.v_front(v_front),
		.v_sync(v_sync),
		.v_back(v_back)
	) timing_i (
		.clk(clk),
		.reset(reset),
		.beam(beam)
	);

	player_motion #(
		.h_display(h_display),
		.v_display(v_display),
		.move_period(move_period)
	) motion_i (
		.clk(clk),
		.reset(reset),
		.buttons(buttons),
		.beam(beam),
		.pos(pos)
	);

	sprite_trigger trigger_i (
		.clk(clk),
		.reset(reset),
		.beam(beam),
		.pos(pos),
		.trig(trig)
	);

	sprite_renderer renderer_i (
		.clk(clk),
		.reset(reset),
		.trig(trig),
		.mirror(mirror),
		.gfx(gfx),
		.in_progress(in_progress)
	);

	pixel_mixer mixer_i (
		.clk(clk),
		.reset(reset),
		.trig(trig),
		.gfx(gfx),
		.in_progress(in_progress),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb)
	);

endmodule

//--- test/sprite_video_tb.sv
module sprite_video_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import sprite_video_pkg::*;

	// small screen so a frame is only 3072 cycles
	localparam int h_display = 48;
	localparam int h_front = 4;
	localparam int h_sync = 6;
	localparam int h_back = 6;
	localparam int v_display = 40;
	localparam int v_front = 2;
	localparam int v_sync = 2;
	localparam int v_back = 4;
	localparam int move_period = 1;
	localparam int h_total = h_display + h_front + h_sync + h_back;
	localparam int v_total = v_display + v_front + v_sync + v_back;
	localparam int hs_start = h_display + h_front;
	localparam int vs_start = v_display + v_front;
	localparam int frame_cycles = h_total * v_total;
	localparam int x_max = h_display - 16;
	localparam int y_max = v_display - 17;

	logic clk;
	logic reset;
	joy_t buttons;
	logic mirror;
	logic hsync;
	logic vsync;
	logic [2:0] rgb;
	logic [3:0] led;

	int h;			// rebuilt beam position of the output sample
	int v;
	logic locked;
	logic hsync_q;
	logic vsync_q;
	int px;			// model of the player corner
	int py;
	int frames_seen;
	int checks;
	int errors;
	int tests;
	logic timed_out;

	sprite_video_top #(
		.h_display(h_display),
		.h_front(h_front),
		.h_sync(h_sync),
		.h_back(h_back),
		.v_display(v_display),
		.v_front(v_front),
		.v_sync(v_sync),
		.v_back(v_back),
		.move_period(move_period)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.buttons(buttons),
		.mirror(mirror),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb),
		.led(led)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one step per frame, left beats right beats up beats down
	task automatic step_model();
		if (buttons.left) begin
			if (px > 0)
				px = px - 1;
		end else if (buttons.right) begin
			if (px < x_max)
				px = px + 1;
		end else if (buttons.up) begin
			if (py > 0)
				py = py - 1;
		end else if (buttons.down) begin
			if (py < y_max)
				py = py + 1;
		end
	endtask

	// red and green for a visible pixel
	function automatic logic [1:0] expect_rg(input int hh, input int vv);
		int r;
		int c;
		int idx;
		r = vv - py - 1;	// sprite starts one line below the corner
		c = hh - px;
		if (r < 0 || r > 15 || c < 0 || c > 15)
			return 2'b00;
		if (mirror && c >= 8)
			idx = 15 - c;
		else
			idx = c;
		return {2{sprite_bitmap[r][idx]}};
	endfunction

	task automatic check_sample();
		logic hs_exp;
		logic vs_exp;
		logic [1:0] rg_exp;
		if (locked) begin
			h = h + 1;
			if (h == h_total) begin
				h = 0;
				v = (v == v_total - 1) ? 0 : v + 1;
			end
		end
		if (vsync && !vsync_q) begin
			checks++;
			assert (!locked || (h == 0 && v == vs_start)) else begin
				errors++;
				$display("vsync rose at h=%0d v=%0d, not at the start of line %0d",
					h, v, vs_start);
			end
			h = 0;
			v = vs_start;
			locked = 1'b1;
			frames_seen++;
			step_model();	// dut moved two cycles earlier
		end
		if (locked && hsync && !hsync_q) begin
			checks++;
			assert (h == hs_start) else begin
				errors++;
				$display("hsync rose at h=%0d on line %0d, not at h=%0d", h, v, hs_start);
			end
		end
		if (locked) begin
			hs_exp = (h >= hs_start) && (h < hs_start + h_sync);
			vs_exp = (v >= vs_start) && (v < vs_start + v_sync);
			checks += 3;
			assert (hsync == hs_exp) else begin
				errors++;
				$display("Mismatch hsync at (%0d,%0d): expected %h, got %h", h, v, hs_exp, hsync);
			end
			assert (vsync == vs_exp) else begin
				errors++;
				$display("Mismatch vsync at (%0d,%0d): expected %h, got %h", h, v, vs_exp, vsync);
			end
			assert (led == buttons) else begin
				errors++;
				$display("Mismatch led: expected %h, got %h", buttons, led);
			end
			if (h >= h_display || v >= v_display) begin
				checks++;
				assert (rgb == 3'b000) else begin
					errors++;
					$display("Mismatch rgb at (%0d,%0d): expected %h, got %h", h, v, 3'b000, rgb);
				end
			end else begin
				rg_exp = expect_rg(h, v);
				checks++;
				assert (rgb[1:0] == rg_exp) else begin
					errors++;
					$display("Mismatch rgb[1:0] at (%0d,%0d): expected %h, got %h",
						h, v, rg_exp, rgb[1:0]);
				end
				// rows y and y+16 are only partly inside the band
				if (v >= py + 1 && v <= py + 15) begin
					checks++;
					assert (rgb[2] == 1'b1) else begin
						errors++;
						$display("Mismatch rgb[2] at (%0d,%0d): expected 1, got %h", h, v, rgb[2]);
					end
				end else if (v < py || v > py + 16) begin
					checks++;
					assert (rgb[2] == 1'b0) else begin
						errors++;
						$display("Mismatch rgb[2] at (%0d,%0d): expected 0, got %h", h, v, rgb[2]);
					end
				end
			end
		end
		hsync_q = hsync;
		vsync_q = vsync;
	endtask

	// also used to find the first frame, checks start once locked
	task automatic run_frames(input int n);
		int limit;
		int start;
		limit = (n + 1) * frame_cycles;
		start = frames_seen;
		while (frames_seen - start < n && limit > 0) begin
			@(negedge clk);
			check_sample();
			limit--;
		end
		if (frames_seen - start < n) begin
			timed_out = 1'b1;
			$display("timed out waiting for vsync, saw %0d of %0d frames", frames_seen - start, n);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before && !timed_out)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	initial begin
		int e0;
		int n;
		logic [31:0] rnd;
		void'($urandom(91));
		reset = 1'b1;
		buttons = '0;
		mirror = 1'b0;
		h = 0;
		v = 0;
		locked = 1'b0;
		hsync_q = 1'b0;
		vsync_q = 1'b0;
		px = h_display / 2;
		py = v_display / 2;
		frames_seen = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		timed_out = 1'b0;

		e0 = errors;
		for (int i = 0; i < 42; i++) begin
			@(negedge clk);
			if (i == 1)
				reset = 1'b0;	// two rising edges seen with reset high
			checks++;
			assert (hsync == 1'b0 && vsync == 1'b0 && rgb == 3'b000) else begin
				errors++;
				$display("Mismatch outputs after reset: expected 0 0 0, got %h %h %h",
					hsync, vsync, rgb);
			end
		end
		report_test("reset state", e0);

		e0 = errors;
		run_frames(1);	// locks onto the first vsync
		if (!timed_out)
			run_frames(2);
		report_test("sync timing and blanking", e0);

		if (!timed_out) begin
			e0 = errors;
			run_frames(2);
			report_test("unmirrored sprite", e0);
		end

		if (!timed_out) begin
			e0 = errors;
			mirror = 1'b1;
			run_frames(2);
			mirror = 1'b0;
			report_test("mirrored sprite", e0);
		end

		if (!timed_out) begin
			e0 = errors;
			buttons = '0;
			buttons.left = 1'b1;
			run_frames(px + 4);	// runs into x = 0 and holds there
			report_test("left limit", e0);
		end

		if (!timed_out) begin
			e0 = errors;
			buttons = '0;
			buttons.down = 1'b1;
			run_frames(y_max - py + 4);
			report_test("bottom limit", e0);
		end

		if (!timed_out) begin
			e0 = errors;
			for (int i = 0; i < 8 && !timed_out; i++) begin
				rnd = $urandom;
				buttons = rnd[3:0];
				n = 2 + int'(rnd[5:4]);
				run_frames(n);
			end
			report_test("random buttons", e0);
		end

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- sprite_video.f
design/sprite_video_pkg.sv
design/video_timing.sv
design/player_motion.sv
design/sprite_trigger.sv
design/sprite_renderer.sv
design/pixel_mixer.sv
design/sprite_video_top.sv
test/sprite_video_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sprite_video_tb -f sprite_video.f || exit 1
out=$(./obj_dir/Vsprite_video_tb)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
